/* logic/sd_emu_pkg.sv */
// sector store shared definitions
package sd_emu_pkg;

   localparam int SECTOR_BYTES = 512; // bytes per sector
   localparam int BYTE_AW = 9; // byte index width
   localparam int SECTOR_COUNT = 8; // sectors held in ram
   localparam int SECTOR_AW = 3; // sector index width
   localparam int RAM_AW = BYTE_AW + SECTOR_AW; // full byte address

   // host register offsets
   localparam logic [31:0] REG_STATUS = 32'd0; // 1 when idle
   localparam logic [31:0] REG_SECTOR = 32'd4; // first sector
   localparam logic [31:0] REG_COUNT = 32'd8; // block count, 0 means 1
   localparam logic [31:0] REG_CMD = 32'd12; // command, starts a transfer

   typedef enum logic [3:0] {
      st_idle = 4'b0001, // waiting for a command
      st_fill = 4'b0010, // floppy buffer into ram
      st_drain = 4'b0100, // ram out to floppy buffer
      st_end = 4'b1000 // one closing cycle
   } ctrl_state_t;

   typedef enum logic [31:0] {
      cmd_none = 32'd0,
      cmd_drain = 32'd2,
      cmd_fill = 32'd3
   } cmd_t;

   typedef struct packed {
      logic [31:0] address; // byte offset of the register
      logic read; // one-cycle read strobe
      logic write; // one-cycle write strobe
      logic [31:0] writedata;
   } host_bus_t;

   typedef struct packed {
      logic start; // one-cycle pulse
      cmd_t op; // fill or drain only
      logic [SECTOR_AW-1:0] first_sector; // already wrapped
      logic [15:0] blocks; // raised to 1 when written as 0
   } xfer_req_t;

   typedef struct packed {
      logic [RAM_AW-1:0] addr; // {sector, byte}
      logic we;
      logic [7:0] wdata;
   } ram_port_t;

endpackage

/* logic/sd_emu_regs.sv */
// host register file
`timescale 1ns/1ps

module sd_emu_regs (
   input logic clk,
   input logic rst,
   input sd_emu_pkg::host_bus_t host,
   input logic busy, // transfer in progress
   output logic [31:0] readdata,
   output logic readdatavalid,
   output sd_emu_pkg::xfer_req_t req
);

   logic [31:0] sector_q; // raw sector register
   logic [31:0] count_q; // raw block count
   logic [31:0] cmd_q; // last command written
   logic cmd_wr; // write to the command offset
   logic cmd_ok; // fill or drain opcode

   assign cmd_wr = host.write && (host.address == sd_emu_pkg::REG_CMD);
   assign cmd_ok = (host.writedata == sd_emu_pkg::cmd_fill) ||
                   (host.writedata == sd_emu_pkg::cmd_drain);

   // start uses the stored sector and count, command byte comes live
   assign req.start = cmd_wr && cmd_ok && !busy; // ignored while busy
   assign req.op = (host.writedata == sd_emu_pkg::cmd_fill) ? sd_emu_pkg::cmd_fill
                                                           : sd_emu_pkg::cmd_drain;
   assign req.first_sector = sector_q[sd_emu_pkg::SECTOR_AW-1:0]; // wraps mod count
   assign req.blocks = (count_q[15:0] == 16'd0) ? 16'd1 : count_q[15:0]; // 0 counts as 1

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sector_q <= '0;
         count_q <= '0;
         cmd_q <= '0;
      end else if (host.write) begin
         case (host.address)
            sd_emu_pkg::REG_SECTOR: sector_q <= host.writedata;
            sd_emu_pkg::REG_COUNT: count_q <= host.writedata;
            sd_emu_pkg::REG_CMD: cmd_q <= host.writedata; // kept even if rejected
            default: ; // status is read only
         endcase
      end
   end

   // valid follows the read strobe by one cycle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         readdatavalid <= 1'b0;
      end else begin
         readdatavalid <= host.read;
      end
   end

   always_ff @(posedge clk) begin
      if (host.read) begin
         case (host.address)
            sd_emu_pkg::REG_STATUS: readdata <= {31'd0, !busy}; // 1 = ready
            sd_emu_pkg::REG_SECTOR: readdata <= sector_q;
            sd_emu_pkg::REG_COUNT: readdata <= count_q;
            sd_emu_pkg::REG_CMD: readdata <= cmd_q;
            default: readdata <= 32'd0; // unmapped offset
         endcase
      end
   end

   // controller must take the start and report busy on the next edge
   a_start_busy: assert property (@(posedge clk) disable iff (rst)
      req.start |-> !busy ##1 busy);

endmodule

/* logic/sd_emu_ctrl.sv */
// transfer sequencer
`timescale 1ns/1ps

module sd_emu_ctrl (
   input logic clk,
   input logic rst,
   input sd_emu_pkg::xfer_req_t req,
   input logic last_byte, // byte index at 511
   input logic last_block, // final block of the run
   output logic step, // advance counters
   output logic clear, // reload counters
   output logic ram_we,
   output logic fdd_read,
   output logic fdd_write,
   output logic busy
);

   sd_emu_pkg::ctrl_state_t state; // current state, one-hot
   sd_emu_pkg::ctrl_state_t state_nxt;
   logic done; // last byte of last block this cycle

   assign done = last_byte && last_block;

   always_comb begin
      state_nxt = state; // hold by default
      case (state)
         sd_emu_pkg::st_idle: begin
            if (req.start) begin
               if (req.op == sd_emu_pkg::cmd_fill) begin
                  state_nxt = sd_emu_pkg::st_fill;
               end else begin
                  state_nxt = sd_emu_pkg::st_drain;
               end
            end
         end
         sd_emu_pkg::st_fill: begin
            if (done) begin
               state_nxt = sd_emu_pkg::st_end;
            end
         end
         sd_emu_pkg::st_drain: begin
            if (done) begin
               state_nxt = sd_emu_pkg::st_end;
            end
         end
         sd_emu_pkg::st_end: state_nxt = sd_emu_pkg::st_idle; // single cycle
         default: state_nxt = sd_emu_pkg::st_idle; // recover from bad code
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= sd_emu_pkg::st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // strobes decoded straight from the state
   assign fdd_read = (state == sd_emu_pkg::st_fill); // byte sampled this cycle
   assign ram_we = (state == sd_emu_pkg::st_fill); // same byte into ram
   assign step = (state == sd_emu_pkg::st_fill) || (state == sd_emu_pkg::st_drain);
   assign clear = req.start && (state == sd_emu_pkg::st_idle);
   assign busy = (state != sd_emu_pkg::st_idle);

   // ram read data lands one cycle after the address, so delay the strobe
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         fdd_write <= 1'b0;
      end else begin
         fdd_write <= (state == sd_emu_pkg::st_drain);
      end
   end

   a_state_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot(state));

   // a drain tail must be finished before a fill can strobe
   a_no_overlap: assert property (@(posedge clk) disable iff (rst)
      !(fdd_read && fdd_write));

endmodule

/* logic/sd_emu_addr.sv */
// sector address counter
`timescale 1ns/1ps

module sd_emu_addr (
   input logic clk,
   input logic rst,
   input logic clear, // load a new run
   input logic [sd_emu_pkg::SECTOR_AW-1:0] first_sector,
   input logic [15:0] blocks, // at least 1
   input logic step, // one byte done
   output logic [sd_emu_pkg::RAM_AW-1:0] ram_addr,
   output logic [sd_emu_pkg::BYTE_AW-1:0] byte_idx,
   output logic last_byte,
   output logic last_block
);

   logic [sd_emu_pkg::BYTE_AW-1:0] byte_q; // byte within sector
   logic [sd_emu_pkg::SECTOR_AW-1:0] sector_q; // wraps mod sector count
   logic [15:0] block_q; // blocks finished
   logic [15:0] blocks_q; // run length, held for the whole run

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         byte_q <= '0;
         sector_q <= '0;
         block_q <= '0;
         blocks_q <= 16'd1;
      end else if (clear) begin
         byte_q <= '0;
         sector_q <= first_sector;
         block_q <= '0;
         blocks_q <= blocks;
      end else if (step) begin
         byte_q <= byte_q + 1'b1; // natural wrap at 512
         if (last_byte) begin
            sector_q <= sector_q + 1'b1; // 7 rolls to 0
            block_q <= block_q + 16'd1;
         end
      end
   end

   assign ram_addr = {sector_q, byte_q};
   assign byte_idx = byte_q;
   assign last_byte = (byte_q == sd_emu_pkg::BYTE_AW'(sd_emu_pkg::SECTOR_BYTES - 1));
   assign last_block = (block_q == blocks_q - 16'd1);

endmodule

/* logic/sd_emu_ram.sv */
// sector memory
`timescale 1ns/1ps

module sd_emu_ram #(
   parameter int DEPTH = sd_emu_pkg::SECTOR_COUNT * sd_emu_pkg::SECTOR_BYTES
) (
   input logic clk,
   input sd_emu_pkg::ram_port_t port,
   output logic [7:0] rdata // valid one cycle after addr
);

   logic [7:0] mem [DEPTH]; // one byte per entry

   // blank media reads as erased
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = 8'hff;
      end
   end

   always_ff @(posedge clk) begin
      if (port.we) begin
         mem[port.addr] <= port.wdata;
         rdata <= port.wdata; // write first, new byte visible
      end else begin
         rdata <= mem[port.addr];
      end
   end

endmodule

/* logic/sd_emu_top.sv */
// floppy sector store emulator
`timescale 1ns/1ps

module sd_emu_top (
   input logic clk,
   input logic rst,
   input sd_emu_pkg::host_bus_t host,
   output logic [31:0] readdata,
   output logic readdatavalid,
   output logic fdd_read, // byte wanted this cycle
   input logic [7:0] fdd_readdata, // answered in the same cycle
   output logic fdd_write, // byte offered this cycle
   output logic [7:0] fdd_writedata,
   output logic [sd_emu_pkg::BYTE_AW-1:0] fdd_address // debug only
);

   sd_emu_pkg::xfer_req_t req; // start, op and run setup
   sd_emu_pkg::ram_port_t ram_port;
   logic busy;
   logic step;
   logic clear;
   logic ram_we;
   logic last_byte;
   logic last_block;
   logic [sd_emu_pkg::RAM_AW-1:0] ram_addr;

   sd_emu_regs u_regs (
      .clk(clk),
      .rst(rst),
      .host(host),
      .busy(busy),
      .readdata(readdata),
      .readdatavalid(readdatavalid),
      .req(req)
   );

   sd_emu_ctrl u_ctrl (
      .clk(clk),
      .rst(rst),
      .req(req),
      .last_byte(last_byte),
      .last_block(last_block),
      .step(step),
      .clear(clear),
      .ram_we(ram_we),
      .fdd_read(fdd_read),
      .fdd_write(fdd_write),
      .busy(busy)
   );

   sd_emu_addr u_addr (
      .clk(clk),
      .rst(rst),
      .clear(clear),
      .first_sector(req.first_sector),
      .blocks(req.blocks),
      .step(step),
      .ram_addr(ram_addr),
      .byte_idx(fdd_address),
      .last_byte(last_byte),
      .last_block(last_block)
   );

   assign ram_port.addr = ram_addr;
   assign ram_port.we = ram_we;
   assign ram_port.wdata = fdd_readdata; // floppy byte straight in

   sd_emu_ram u_ram (
      .clk(clk),
      .port(ram_port),
      .rdata(fdd_writedata) // straight out to the floppy buffer
   );

endmodule

/* dv/sd_emu_checker.sv */
// sector store result checker
`timescale 1ns/1ps

module sd_emu_checker (
   input logic clk,
   input logic rst,
   input sd_emu_pkg::host_bus_t host,
   input logic [31:0] readdata,
   input logic readdatavalid,
   input logic fdd_read,
   input logic [7:0] fdd_readdata,
   input logic fdd_write,
   input logic [7:0] fdd_writedata,
   input logic [sd_emu_pkg::BYTE_AW-1:0] fdd_address,
   output int errors, // all mismatches so far
   output int tests_done
);

   logic [7:0] img [sd_emu_pkg::SECTOR_COUNT * sd_emu_pkg::SECTOR_BYTES]; // expected ram
   logic [31:0] sec_reg = '0; // host register mirror
   logic [31:0] cnt_reg = '0;
   logic [31:0] cmd_reg = '0;
   logic [sd_emu_pkg::SECTOR_AW-1:0] cur_sec = '0; // model sector of the run
   logic [sd_emu_pkg::BYTE_AW-1:0] byte_cnt = '0; // model byte of the sector
   int busy_cnt = 0; // busy cycles still ahead
   logic rd_pend = 1'b0; // read issued last cycle
   logic [31:0] rd_exp = '0;
   int cycle_errs = 0;
   int end_errs = 0;
   int strobes = 0; // fdd_read plus fdd_write pulses
   int strobes_at_start = 0;
   int errs_at_start = 0;
   int exp_strobes = 0;
   string cur_name = "reset";

   assign errors = cycle_errs + end_errs;

   // blank media is all ones
   initial begin
      tests_done = 0;
      for (int i = 0; i < sd_emu_pkg::SECTOR_COUNT * sd_emu_pkg::SECTOR_BYTES; i++) begin
         img[i] = 8'hff;
      end
   end

   always @(posedge clk) begin
      logic idle_now; // model busy before this edge
      logic [15:0] blk;
      if (!rst) begin
         idle_now = (busy_cnt == 0);
         if (rd_pend && !readdatavalid) begin
            $display("%s: readdatavalid did not follow the read by one cycle", cur_name);
            cycle_errs++;
         end else if (rd_pend && readdata !== rd_exp) begin
            $display("FAIL %s readdata expected %h actual %h", cur_name, rd_exp, readdata);
            cycle_errs++;
         end else if (!rd_pend && readdatavalid) begin
            $display("%s: readdatavalid rose without a read", cur_name);
            cycle_errs++;
         end
         rd_pend = host.read;
         if (host.read) begin
            case (host.address)
               sd_emu_pkg::REG_STATUS: rd_exp = idle_now ? 32'd1 : 32'd0; // 1 = ready
               sd_emu_pkg::REG_SECTOR: rd_exp = sec_reg;
               sd_emu_pkg::REG_COUNT: rd_exp = cnt_reg;
               sd_emu_pkg::REG_CMD: rd_exp = cmd_reg;
               default: rd_exp = 32'd0;
            endcase
         end
         if (fdd_read) begin // fill byte lands in the image
            strobes++;
            if (fdd_address !== byte_cnt) begin
               $display("FAIL %s fdd_address expected %0d actual %0d",
                        cur_name, byte_cnt, fdd_address);
               cycle_errs++;
            end
            img[{cur_sec, byte_cnt}] = fdd_readdata;
         end
         if (fdd_write) begin // drained byte against the image
            strobes++;
            if (fdd_writedata !== img[{cur_sec, byte_cnt}]) begin
               $display("FAIL %s drain byte %0d expected %h actual %h", cur_name,
                        {cur_sec, byte_cnt}, img[{cur_sec, byte_cnt}], fdd_writedata);
               cycle_errs++;
            end
         end
         if (fdd_read || fdd_write) begin
            if (byte_cnt == '1) begin
               cur_sec = cur_sec + 1'b1; // wraps 7 to 0
            end
            byte_cnt = byte_cnt + 1'b1;
         end
         if (busy_cnt != 0) begin
            busy_cnt--;
         end
         if (host.write) begin
            case (host.address)
               sd_emu_pkg::REG_SECTOR: sec_reg = host.writedata;
               sd_emu_pkg::REG_COUNT: cnt_reg = host.writedata;
               sd_emu_pkg::REG_CMD: cmd_reg = host.writedata; // stored even if ignored
               default: ;
            endcase
            if (host.address == sd_emu_pkg::REG_CMD && idle_now &&
                (host.writedata == 32'd2 || host.writedata == 32'd3)) begin
               blk = (cnt_reg[15:0] == 16'd0) ? 16'd1 : cnt_reg[15:0]; // 0 means 1
               busy_cnt = sd_emu_pkg::SECTOR_BYTES * int'(blk) + 1; // run plus end cycle
               cur_sec = sec_reg[sd_emu_pkg::SECTOR_AW-1:0];
               byte_cnt = '0;
            end
         end
      end
   end

   task automatic begin_test(input string name, input int exp_pulses);
      cur_name = name;
      exp_strobes = exp_pulses;
      strobes_at_start = strobes;
      errs_at_start = cycle_errs + end_errs;
   endtask

   task automatic end_test();
      int seen;
      seen = strobes - strobes_at_start;
      if (seen != exp_strobes) begin
         $display("FAIL %s strobes expected %0d actual %0d", cur_name, exp_strobes, seen);
         end_errs++;
      end
      tests_done++;
      if (cycle_errs + end_errs == errs_at_start) begin
         $display("test %s passed, %0d strobes", cur_name, seen);
      end else begin
         $display("test %s finished with %0d errors", cur_name,
                  cycle_errs + end_errs - errs_at_start);
      end
   endtask

endmodule

/* dv/sd_emu_tb.sv */
// sector store testbench
`timescale 1ns/1ps

module sd_emu_tb;

   typedef struct packed {
      logic [31:0] sector;
      logic [31:0] count;
      logic [31:0] cmd;
      logic extra; // second command while busy
      logic [15:0] strobes; // fdd_read plus fdd_write pulses
   } test_row_t;

   logic clk;
   logic rst;
   sd_emu_pkg::host_bus_t host;
   logic [31:0] readdata;
   logic readdatavalid;
   logic fdd_read;
   logic [7:0] fdd_readdata;
   logic fdd_write;
   logic [7:0] fdd_writedata;
   logic [sd_emu_pkg::BYTE_AW-1:0] fdd_address;
   logic [7:0] fbuf [1024]; // floppy side source bytes
   logic blk_off = 1'b0; // block within a fill run
   int chk_errors;
   int tests_done;
   int tb_errors = 0;
   int cycles = 0;
   int limit = 1000000;

   test_row_t rows [8] = '{
      '{32'd6, 32'd3, 32'd0, 1'b0, 16'd0}, // cmd_none, regs only
      '{32'd3, 32'd1, 32'd3, 1'b0, 16'd512},
      '{32'd3, 32'd1, 32'd2, 1'b0, 16'd512},
      '{32'd7, 32'd2, 32'd3, 1'b0, 16'd1024}, // wraps into sector 0
      '{32'd0, 32'd1, 32'd2, 1'b0, 16'd512},
      '{32'd1, 32'd0, 32'd3, 1'b1, 16'd512}, // count 0 runs one block
      '{32'd2, 32'd1, 32'd5, 1'b0, 16'd0}, // unknown opcode
      '{32'd6, 32'd1, 32'd2, 1'b0, 16'd512} // never filled
   };
   string names [8] = '{"reg_readback", "fill_s3", "drain_s3", "fill_wrap",
                        "drain_s0", "busy_cmd", "cmd_five", "blank_drain"};

   sd_emu_top UUT (
      .clk(clk),
      .rst(rst),
      .host(host),
      .readdata(readdata),
      .readdatavalid(readdatavalid),
      .fdd_read(fdd_read),
      .fdd_readdata(fdd_readdata),
      .fdd_write(fdd_write),
      .fdd_writedata(fdd_writedata),
      .fdd_address(fdd_address)
   );

   sd_emu_checker chk (
      .clk(clk),
      .rst(rst),
      .host(host),
      .readdata(readdata),
      .readdatavalid(readdatavalid),
      .fdd_read(fdd_read),
      .fdd_readdata(fdd_readdata),
      .fdd_write(fdd_write),
      .fdd_writedata(fdd_writedata),
      .fdd_address(fdd_address),
      .errors(chk_errors),
      .tests_done(tests_done)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // floppy buffer answers in the same cycle
   assign fdd_readdata = fbuf[{blk_off, fdd_address}];

   always @(posedge clk) begin
      if (!fdd_read) begin
         blk_off <= 1'b0; // new run starts at buffer byte 0
      end else if (fdd_address == '1) begin
         blk_off <= ~blk_off;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
         $display("timeout: the run did not finish within %0d cycles", limit);
         $display("Something failed");
         $finish;
      end
   end

   function automatic int cycle_budget();
      int sum;
      logic [15:0] blk;
      sum = 8; // reset
      foreach (rows[i]) begin
         blk = (rows[i].count[15:0] == 16'd0) ? 16'd1 : rows[i].count[15:0];
         sum += sd_emu_pkg::SECTOR_BYTES * int'(blk) + 100;
      end
      return sum;
   endfunction

   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
      @(posedge clk);
      host <= '{address: addr, read: 1'b0, write: 1'b1, writedata: data};
      @(posedge clk);
      host <= '0;
   endtask

   task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
      @(posedge clk);
      host <= '{address: addr, read: 1'b1, write: 1'b0, writedata: 32'd0};
      @(posedge clk);
      host <= '0;
      @(negedge clk); // valid one cycle after the read
      if (readdatavalid) begin
         data = readdata;
      end else begin
         $display("no readdatavalid after the read of offset %0d", addr);
         tb_errors++;
         data = 32'd0;
      end
   endtask

   initial begin
      logic [31:0] rd;
      rst = 1'b1;
      host = '0;
      void'($urandom(4202));
      for (int i = 0; i < 1024; i++) begin
         fbuf[i] = 8'($urandom());
      end
      limit = cycle_budget();
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      foreach (rows[i]) begin
         chk.begin_test(names[i], int'(rows[i].strobes));
         bus_write(sd_emu_pkg::REG_SECTOR, rows[i].sector);
         bus_write(sd_emu_pkg::REG_COUNT, rows[i].count);
         bus_write(sd_emu_pkg::REG_CMD, rows[i].cmd);
         if (rows[i].extra) begin
            bus_write(sd_emu_pkg::REG_CMD, 32'd2); // must be ignored
         end
         bus_read(sd_emu_pkg::REG_SECTOR, rd);
         bus_read(sd_emu_pkg::REG_COUNT, rd);
         bus_read(sd_emu_pkg::REG_CMD, rd); // last command, kept even if rejected
         rd = 32'd0;
         while (rd != 32'd1) begin
            bus_read(sd_emu_pkg::REG_STATUS, rd); // poll until idle
         end
         chk.end_test();
      end
      $display("tests %0d, errors %0d", tests_done, chk_errors + tb_errors);
      if (chk_errors + tb_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

/* sd_emu_top.f */
logic/sd_emu_pkg.sv
logic/sd_emu_regs.sv
logic/sd_emu_ctrl.sv
logic/sd_emu_addr.sv
logic/sd_emu_ram.sv
logic/sd_emu_top.sv
dv/sd_emu_checker.sv
dv/sd_emu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the sector store testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 \
   --top-module sd_emu_tb \
   -f sd_emu_top.f \
   -o sd_emu_sim

./obj_dir/sd_emu_sim | tee sim.log

if grep -q "Something failed" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi

echo "simulation finished without failures"
